// ==== common/ipt_pkg.sv ====
package ipt_pkg;

	// ======================================================================
	// Field widths
	// ======================================================================

	// Address space id width
	localparam int ASID_W  = 10;
	// Virtual page number width
	localparam int VA_W    = 32;
	// Width of the table hash
	localparam int HASH_W  = 16;
	// Physical page number width
	localparam int PPN_W   = 20;
	// Request tag width, enough for sixteen lookups in flight
	localparam int TAG_W   = 4;
	// The hash mask is a full word
	localparam int MASK_W  = 32;
	// Chain link index width, must equal the per-bank index width
	localparam int LINK_W  = 8;
	// Probe counter width in a result
	localparam int PROBE_W = 3;

	typedef logic [VA_W-1:0] vaddr_t;

	// ======================================================================
	// Payload structs
	// ======================================================================

	// One translation request from the host
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [ASID_W-1:0] asid;
		vaddr_t            vpn;
		logic [MASK_W-1:0] mask;
	} ipt_req_t;

	// One inverted page table entry, link points into the same bank
	typedef struct packed {
		logic              valid;
		logic [ASID_W-1:0] asid;
		vaddr_t            vpn;
		logic [PPN_W-1:0]  ppn;
		logic              link_valid;
		logic [LINK_W-1:0] link;
	} ipt_entry_t;

	// One lookup result; ppn is zero on a miss
	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic               hit;
		logic [PPN_W-1:0]   ppn;
		logic [PROBE_W-1:0] probes;
	} ipt_result_t;

endpackage

// ==== hw/ipt_hash.sv ====
`timescale 1ns/1ns

module ipt_hash import ipt_pkg::*; (
	input  logic [ASID_W-1:0] asid,
	input  vaddr_t            vpn,
	input  logic [MASK_W-1:0] mask,
	output logic [HASH_W-1:0] hash
);

	// Shift amount taken from the lowest set mask bit
	logic [4:0]        sh;
	// Asid moved up to where the mask starts
	logic [VA_W-1:0]   asid_sh;
	// Low ten bits always pass, the mask gates the bits above them
	logic [VA_W+9:0]   mask_r;
	logic [VA_W-1:0]   mixed;

	// Scan from the top so the last hit is the lowest set bit
	// A zero mask leaves the shift at zero
	always_comb begin
		sh = 5'd0;
		for (int i = MASK_W - 1; i >= 0; i--) begin
			if (mask[i])
				sh = i[4:0];
		end
	end

	always_comb
		asid_sh = {{(VA_W-ASID_W){1'b0}}, asid} << sh;

	always_comb
		mask_r = {mask, 10'h3FF};

	// Fold the asid into the page number
	always_comb
		mixed = vpn ^ asid_sh;

	// Only the low HASH_W bits are kept
	always_comb
		hash = mixed[HASH_W-1:0] & mask_r[HASH_W-1:0];

endmodule

// ==== hw/ipt_fifo.sv ====
`timescale 1ns/1ns

module ipt_fifo #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  T     din,
	input  logic pop,
	output T     dout,
	output logic empty,
	output logic full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Payload storage, contents are don't care until written
	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// A push into a full FIFO or a pop from an empty one is dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk)
		if (do_push)
			mem[wr_ptr] <= din;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap at DEPTH so any depth works
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head entry is visible without a pop
	assign dout  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

endmodule

// ==== hw/ipt_dispatch.sv ====
`timescale 1ns/1ns

module ipt_dispatch import ipt_pkg::*; #(
	parameter int N_WALK = 4,
	parameter int IDX_W  = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  ipt_req_t          req,
	input  logic [N_WALK-1:0] walk_full,
	output logic              busy,
	output logic [N_WALK-1:0] push,
	output ipt_req_t          push_req,
	output logic [IDX_W-1:0]  push_idx,
	output logic [HASH_W-1:0] push_hash
);

	localparam int BANK_W = $clog2(N_WALK);

	// Registered copy of the host request
	logic              hold_valid;
	ipt_req_t          hold_req;
	logic [HASH_W-1:0] hash;
	logic [BANK_W-1:0] bank;
	logic              pushed;

	always_ff @(posedge clk)
		if (req_valid)
			hold_req <= req;

	// The request waits here until its bank has room
	always_ff @(posedge clk) begin
		if (!rst_n)
			hold_valid <= 1'b0;
		else if (req_valid)
			hold_valid <= 1'b1;
		else if (pushed)
			hold_valid <= 1'b0;
	end

	ipt_hash u_hash (
		.asid (hold_req.asid),
		.vpn  (hold_req.vpn),
		.mask (hold_req.mask),
		.hash (hash)
	);

	// Low hash bits select the bank, the next bits the start entry
	assign bank     = hash[BANK_W-1:0];
	assign push_idx = hash[BANK_W +: IDX_W];

	assign pushed = hold_valid && !walk_full[bank];

	// Only the owning walker sees a strobe
	always_comb begin
		push = '0;
		push[bank] = pushed;
	end

	assign push_req  = hold_req;
	assign push_hash = hash;

	// Host must wait while a request is held or any queue is full
	assign busy = hold_valid || (|walk_full);

endmodule

// ==== hw/ipt_collect.sv ====
`timescale 1ns/1ns

module ipt_collect import ipt_pkg::*; #(
	parameter int N_WALK = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [N_WALK-1:0] res_avail,
	input  ipt_result_t       res_in [N_WALK],
	output logic [N_WALK-1:0] pop,
	output logic              res_valid,
	output ipt_result_t       res
);

	localparam int SEL_W = $clog2(N_WALK);

	// Walker served most recently
	logic [SEL_W-1:0] last;
	logic [SEL_W-1:0] sel;
	logic             found;

	// ======================================================================
	// Round robin pick, searching from the walker after the last one served
	// ======================================================================

	always_comb begin
		int j;
		sel   = '0;
		found = 1'b0;
		for (int k = 1; k <= N_WALK; k++) begin
			j = (int'(last) + k) % N_WALK;
			if (!found && res_avail[j]) begin
				found = 1'b1;
				sel   = SEL_W'(j);
			end
		end
	end

	// At most one walker is popped per cycle
	always_comb begin
		pop = '0;
		pop[sel] = found;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// Start so that walker 0 has first turn
			last      <= SEL_W'(N_WALK - 1);
			res_valid <= 1'b0;
		end else begin
			res_valid <= found;
			if (found)
				last <= sel;
		end
	end

	// Result payload follows the pop by one cycle
	always_ff @(posedge clk)
		if (found)
			res <= res_in[sel];

endmodule

// ==== ipt_walk/ipt_table_ram.sv ====
`timescale 1ns/1ns

module ipt_table_ram import ipt_pkg::*; #(
	parameter int IDX_W = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             we,
	input  logic [IDX_W-1:0] waddr,
	input  ipt_entry_t       wdata,
	input  logic [IDX_W-1:0] raddr,
	output ipt_entry_t       rdata
);

	localparam int DEPTH = 1 << IDX_W;

	// Entry storage for one bank
	ipt_entry_t       mem [DEPTH];
	// Valid bits live in flops so that reset clears every entry at once
	logic [DEPTH-1:0] vld;
	ipt_entry_t       rd_q;
	logic             vld_q;

	always_ff @(posedge clk)
		if (we)
			mem[waddr] <= wdata;

	always_ff @(posedge clk) begin
		if (!rst_n)
			vld <= '0;
		else if (we)
			vld[waddr] <= wdata.valid;
	end

	// Synchronous read, old data is returned on a same-address write
	always_ff @(posedge clk) begin
		rd_q  <= mem[raddr];
		vld_q <= vld[raddr];
	end

	always_comb begin
		rdata       = rd_q;
		rdata.valid = vld_q;
	end

endmodule

// ==== ipt_walk/ipt_walker.sv ====
`timescale 1ns/1ns

module ipt_walker import ipt_pkg::*; #(
	parameter int IDX_W      = 8,
	parameter int MAX_PROBES = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              push,
	input  ipt_req_t          push_req,
	input  logic [IDX_W-1:0]  push_idx,
	input  logic [HASH_W-1:0] push_hash,
	input  logic              we,
	input  logic [IDX_W-1:0]  waddr,
	input  ipt_entry_t        wdata,
	input  logic              pop,
	output logic              full,
	output logic              res_avail,
	output ipt_result_t       res
);

	// Queued request with its start entry and the hash it came from
	typedef struct packed {
		ipt_req_t          req;
		logic [IDX_W-1:0]  idx;
		logic [HASH_W-1:0] hash;
	} walk_req_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_CMP
	} state_t;

	state_t             state;
	walk_req_t          q_din;
	walk_req_t          q_head;
	logic               q_empty;
	logic               q_pop;
	logic [IDX_W-1:0]   rd_idx;
	logic [PROBE_W-1:0] probes;
	ipt_entry_t         entry;
	logic               match;
	logic               chain;
	logic               res_push;
	logic               res_full;
	logic               res_empty;
	ipt_result_t        res_din;

	// ======================================================================
	// Request queue
	// ======================================================================

	assign q_din = '{req: push_req, idx: push_idx, hash: push_hash};

	ipt_fifo #(
		.T     (walk_req_t),
		.DEPTH (FIFO_DEPTH)
	) u_req_q (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (push),
		.din   (q_din),
		.pop   (q_pop),
		.dout  (q_head),
		.empty (q_empty),
		.full  (full)
	);

	ipt_table_ram #(
		.IDX_W (IDX_W)
	) u_ram (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (we),
		.waddr (waddr),
		.wdata (wdata),
		.raddr (rd_idx),
		.rdata (entry)
	);

	// ======================================================================
	// Chain walk
	// ======================================================================

	// Entry belongs to the requested page
	assign match = entry.valid && (entry.asid == q_head.req.asid) &&
		(entry.vpn == q_head.req.vpn);
	// Another probe is allowed only below the limit
	assign chain = entry.link_valid && (probes < PROBE_W'(MAX_PROBES));

	// The walk ends in the compare cycle on a hit or a dead end
	assign res_push = (state == S_CMP) && (match || !chain);
	assign q_pop    = res_push;

	always_comb begin
		res_din.tag    = q_head.req.tag;
		res_din.hit    = match;
		res_din.ppn    = match ? entry.ppn : '0;
		res_din.probes = probes;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= S_IDLE;
			rd_idx <= '0;
			probes <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					// The head request stays in the queue until its result is written
					if (!q_empty) begin
						rd_idx <= q_head.idx;
						probes <= '0;
						state  <= S_READ;
					end
				end
				S_READ: begin
					// RAM address is presented here; wait if no room for a result
					if (!res_full) begin
						probes <= probes + 1'b1;
						state  <= S_CMP;
					end
				end
				S_CMP: begin
					if (res_push) begin
						state <= S_IDLE;
					end else begin
						rd_idx <= entry.link[IDX_W-1:0];
						state  <= S_READ;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Result queue
	// ======================================================================

	ipt_fifo #(
		.T     (ipt_result_t),
		.DEPTH (FIFO_DEPTH)
	) u_res_q (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (res_push),
		.din   (res_din),
		.pop   (pop),
		.dout  (res),
		.empty (res_empty),
		.full  (res_full)
	);

	assign res_avail = !res_empty;

endmodule

// ==== hw/ipt_mmu_top.sv ====
`timescale 1ns/1ns

module ipt_mmu_top import ipt_pkg::*; #(
	parameter int N_WALK     = 4,
	parameter int IDX_W      = 8,
	parameter int MAX_PROBES = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req_valid,
	input  ipt_req_t                  req,
	input  logic                      tbl_we,
	input  logic [$clog2(N_WALK)-1:0] tbl_bank,
	input  logic [IDX_W-1:0]          tbl_idx,
	input  ipt_entry_t                tbl_entry,
	output logic                      busy,
	output logic                      res_valid,
	output ipt_result_t               res
);

	logic [N_WALK-1:0] walk_push;
	logic [N_WALK-1:0] walk_full;
	logic [N_WALK-1:0] walk_avail;
	logic [N_WALK-1:0] walk_pop;
	logic [N_WALK-1:0] walk_we;
	ipt_req_t          push_req;
	logic [IDX_W-1:0]  push_idx;
	logic [HASH_W-1:0] push_hash;
	ipt_result_t       walk_res [N_WALK];

	// Entry links must be able to reach every index of a bank
	if (IDX_W != LINK_W) begin : g_link_chk
		$error("IDX_W must equal the entry link width");
	end

	ipt_dispatch #(
		.N_WALK (N_WALK),
		.IDX_W  (IDX_W)
	) u_dispatch (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.walk_full (walk_full),
		.busy      (busy),
		.push      (walk_push),
		.push_req  (push_req),
		.push_idx  (push_idx),
		.push_hash (push_hash)
	);

	// ======================================================================
	// One walker per bank
	// ======================================================================

	for (genvar i = 0; i < N_WALK; i++) begin : g_walk
		// Host table writes go only to the addressed bank
		assign walk_we[i] = tbl_we && (tbl_bank == i);

		ipt_walker #(
			.IDX_W      (IDX_W),
			.MAX_PROBES (MAX_PROBES),
			.FIFO_DEPTH (FIFO_DEPTH)
		) u_walker (
			.clk       (clk),
			.rst_n     (rst_n),
			.push      (walk_push[i]),
			.push_req  (push_req),
			.push_idx  (push_idx),
			.push_hash (push_hash),
			.we        (walk_we[i]),
			.waddr     (tbl_idx),
			.wdata     (tbl_entry),
			.pop       (walk_pop[i]),
			.full      (walk_full[i]),
			.res_avail (walk_avail[i]),
			.res       (walk_res[i])
		);
	end

	ipt_collect #(
		.N_WALK (N_WALK)
	) u_collect (
		.clk       (clk),
		.rst_n     (rst_n),
		.res_avail (walk_avail),
		.res_in    (walk_res),
		.pop       (walk_pop),
		.res_valid (res_valid),
		.res       (res)
	);

endmodule

// ==== tb/ipt_mmu_props.sv ====
`timescale 1ns/1ns

module ipt_mmu_props import ipt_pkg::*; #(
	parameter int N_WALK     = 4,
	parameter int MAX_PROBES = 4
) (
	input logic              clk,
	input logic              rst_n,
	input logic              req_valid,
	input logic              busy,
	input logic              res_valid,
	input ipt_result_t       res,
	input logic [N_WALK-1:0] walk_pop
);

	// Number of assertion failures, read by the testbench at the end
	int fail_cnt = 0;

	// Once rst_n was low at an edge, the outputs must be quiet at the next one
	a_reset_quiet: assert property (@(posedge clk) $past(!rst_n) |-> (!res_valid && !busy))
		else begin
			fail_cnt++;
			$error("busy or res_valid high during reset or in the first cycle after it");
		end

	// The host may only strobe a request while the unit is ready
	a_req_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> !busy)
		else begin
			fail_cnt++;
			$error("req_valid arrived while busy was high");
		end

	// A walk never reads more entries than the chain limit
	a_probe_limit: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> (res.probes <= PROBE_W'(MAX_PROBES)))
		else begin
			fail_cnt++;
			$error("result reports more than the allowed number of probes");
		end

	// The collector serves a single walker per cycle
	a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(walk_pop))
		else begin
			fail_cnt++;
			$error("collector popped more than one walker in one cycle");
		end

endmodule

bind ipt_mmu_top ipt_mmu_props #(
	.N_WALK     (N_WALK),
	.MAX_PROBES (MAX_PROBES)
) u_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.req_valid (req_valid),
	.busy      (busy),
	.res_valid (res_valid),
	.res       (res),
	.walk_pop  (walk_pop)
);

// ==== tb/ipt_mmu_tb.sv ====
`timescale 1ns/1ns

module ipt_mmu_tb import ipt_pkg::*; ();

	localparam int N_WALK     = 4;
	localparam int IDX_W      = 8;
	localparam int MAX_PROBES = 4;
	localparam int FIFO_DEPTH = 4;
	localparam int BANK_W     = $clog2(N_WALK);
	localparam int TBL_DEPTH  = 1 << IDX_W;
	localparam int N_TAG      = 1 << TAG_W;
	localparam int CLK_NS     = 20;
	localparam int N_RAND     = 40;
	localparam int N_BURST    = 16;
	// Requests issued over all tests
	localparam int N_REQ      = 6 + N_RAND + N_BURST;
	// Worst case cycles that one lookup may need from strobe to result
	localparam int REQ_CYC    = 2 * MAX_PROBES + 8;
	// Two full table fills at two cycles per write, plus directed writes
	localparam int WR_CYC     = 2 * 2 * N_WALK * TBL_DEPTH + 400;
	localparam int WD_CYC     = N_REQ * REQ_CYC + WR_CYC + 1000;
	localparam int WAIT_CYC   = N_TAG * REQ_CYC + 50;

	logic                clk;
	logic                rst_n;
	logic                req_valid;
	ipt_req_t            req;
	logic                tbl_we;
	logic [BANK_W-1:0]   tbl_bank;
	logic [IDX_W-1:0]    tbl_idx;
	ipt_entry_t          tbl_entry;
	logic                busy;
	logic                res_valid;
	ipt_result_t         res;

	// Mirror of every table write
	ipt_entry_t  model [N_WALK][TBL_DEPTH];
	// Expected result and outstanding flag for each tag
	ipt_result_t exp_q [N_TAG];
	bit          pending [N_TAG];
	int          outstanding;
	int          errors;
	int          test_err0;
	int          n_pass;
	int          n_fail;
	int          seed;
	bit          busy_seen;
	ipt_req_t    r;
	ipt_entry_t  e;
	ipt_req_t    rq [N_RAND];
	ipt_req_t    bq [N_BURST];
	logic [31:0] m;

	ipt_mmu_top #(
		.N_WALK     (N_WALK),
		.IDX_W      (IDX_W),
		.MAX_PROBES (MAX_PROBES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.tbl_we    (tbl_we),
		.tbl_bank  (tbl_bank),
		.tbl_idx   (tbl_idx),
		.tbl_entry (tbl_entry),
		.busy      (busy),
		.res_valid (res_valid),
		.res       (res)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// ======================================================================
	// Reference model
	// ======================================================================

	// The asid is moved up to the lowest mask bit and XORed into the vpn
	function automatic logic [HASH_W-1:0] hash_of(input ipt_req_t q);
		int                sh;
		bit                found;
		logic [VA_W-1:0]   mixed;
		logic [HASH_W-1:0] h;
		sh    = 0;
		found = 1'b0;
		for (int i = 0; i < MASK_W; i++) begin
			if (!found && q.mask[i]) begin
				sh    = i;
				found = 1'b1;
			end
		end
		mixed = q.vpn ^ ({{(VA_W-ASID_W){1'b0}}, q.asid} << sh);
		// Bits above nine survive only where the mask ten places lower is set
		for (int k = 0; k < HASH_W; k++) begin
			if (k < 10)
				h[k] = mixed[k];
			else
				h[k] = mixed[k] & q.mask[k-10];
		end
		return h;
	endfunction

	function automatic int bank_of(input ipt_req_t q);
		return int'(hash_of(q)) & (N_WALK - 1);
	endfunction

	function automatic int start_of(input ipt_req_t q);
		return (int'(hash_of(q)) >> BANK_W) & (TBL_DEPTH - 1);
	endfunction

	// Walk rule applied to the model table
	function automatic ipt_result_t ref_lookup(input ipt_req_t q);
		ipt_result_t x;
		ipt_entry_t  ent;
		int          bank;
		int          idx;
		int          n;
		bit          done;
		bank = bank_of(q);
		idx  = start_of(q);
		x    = '0;
		n    = 0;
		done = 1'b0;
		x.tag = q.tag;
		while (!done) begin
			ent = model[bank][idx];
			n++;
			if (ent.valid && ent.asid == q.asid && ent.vpn == q.vpn) begin
				x.hit = 1'b1;
				x.ppn = ent.ppn;
				done  = 1'b1;
			end else if (ent.link_valid && n < MAX_PROBES) begin
				idx = ent.link;
			end else begin
				done = 1'b1;
			end
		end
		x.probes = PROBE_W'(n);
		return x;
	endfunction

	function automatic ipt_req_t make_req(input int tag, input logic [ASID_W-1:0] asid,
		input vaddr_t vpn, input logic [MASK_W-1:0] mask);
		ipt_req_t q;
		q.tag  = TAG_W'(tag);
		q.asid = asid;
		q.vpn  = vpn;
		q.mask = mask;
		return q;
	endfunction

	function automatic ipt_result_t expect_res(input int tag, input bit hit,
		input logic [PPN_W-1:0] ppn, input int probes);
		ipt_result_t x;
		x.tag    = TAG_W'(tag);
		x.hit    = hit;
		x.ppn    = ppn;
		x.probes = PROBE_W'(probes);
		return x;
	endfunction

	function automatic ipt_entry_t rand_entry();
		ipt_entry_t x;
		x.valid      = $random(seed);
		x.asid       = $random(seed);
		x.vpn        = $random(seed);
		x.ppn        = $random(seed);
		x.link_valid = $random(seed);
		x.link       = $random(seed);
		return x;
	endfunction

	// ======================================================================
	// Checks
	// ======================================================================

	task automatic check_result(input ipt_result_t exp, input ipt_result_t act);
		if (act !== exp) begin
			$display("ERR %0t res: expected tag=%0d hit=%0b ppn=%h probes=%0d, ", $time,
				exp.tag, exp.hit, exp.ppn, exp.probes,
				"got tag=%0d hit=%0b ppn=%h probes=%0d",
				act.tag, act.hit, act.ppn, act.probes);
			errors++;
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %0t %s: expected %b, got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	// Results are sampled mid cycle, where the registered outputs are settled
	always @(negedge clk) begin
		if (rst_n === 1'b1 && res_valid === 1'b1) begin
			if (!pending[res.tag]) begin
				$display("[%0t] a result for tag %0d came back with no request outstanding",
					$time, res.tag);
				errors++;
			end else begin
				check_result(exp_q[res.tag], res);
				pending[res.tag] = 1'b0;
				outstanding--;
			end
		end
	end

	// Ends a run that stopped making progress
	initial begin
		#(WD_CYC * CLK_NS);
		$display("[%0t] watchdog expired with %0d lookups still outstanding", $time, outstanding);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	// One host write; the RAM takes it at the rising edge in between
	task automatic write_entry(input int bank, input int idx, input ipt_entry_t ent);
		@(negedge clk);
		tbl_we    = 1'b1;
		tbl_bank  = BANK_W'(bank);
		tbl_idx   = IDX_W'(idx);
		tbl_entry = ent;
		model[bank][idx] = ent;
		@(negedge clk);
		tbl_we = 1'b0;
	endtask

	// Invalid entries carry a pattern built from bank and index, random ones do not
	task automatic fill_table(input bit rnd);
		ipt_entry_t ent;
		for (int b = 0; b < N_WALK; b++) begin
			for (int i = 0; i < TBL_DEPTH; i++) begin
				if (rnd) begin
					ent = rand_entry();
				end else begin
					ent = '0;
					ent.asid = ASID_W'(b * TBL_DEPTH + i);
					ent.vpn  = ~vaddr_t'(b * TBL_DEPTH + i);
					ent.ppn  = PPN_W'((b << IDX_W) | i) ^ 20'hA5A5A;
				end
				write_entry(b, i, ent);
			end
		end
	endtask

	// Writes an entry at the start position of a request
	task automatic plant(input ipt_req_t q, input ipt_entry_t ent);
		write_entry(bank_of(q), start_of(q), ent);
	endtask

	// Chain of len entries from the start position; the last one holds the page
	task automatic build_chain(input ipt_req_t q, input int len, input bit asid_bad,
		input logic [PPN_W-1:0] ppn);
		ipt_entry_t ent;
		int         start;
		start = start_of(q);
		for (int i = 0; i < len; i++) begin
			// Odd links hold an invalid copy of the page, even ones a valid other page
			ent.valid      = (i % 2 == 0);
			ent.asid       = q.asid;
			ent.vpn        = (i % 2 == 0) ? (q.vpn ^ 32'h0000_0100) : q.vpn;
			ent.ppn        = ppn ^ PPN_W'(i + 1);
			ent.link_valid = (i < len - 1);
			ent.link       = LINK_W'((start + i + 1) % TBL_DEPTH);
			if (i == len - 1) begin
				ent.valid = 1'b1;
				ent.vpn   = q.vpn;
				ent.ppn   = ppn;
				if (asid_bad)
					ent.asid = q.asid ^ 10'h001;
			end
			write_entry(bank_of(q), (start + i) % TBL_DEPTH, ent);
		end
	endtask

	// Strobes one request as soon as busy is low
	task automatic send_req(input ipt_req_t q);
		@(negedge clk);
		while (busy !== 1'b0) begin
			busy_seen = 1'b1;
			@(negedge clk);
		end
		req_valid = 1'b1;
		req       = q;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic issue(input ipt_req_t q, input ipt_result_t exp);
		int n;
		n = 0;
		// A tag is reused only after its previous result came back
		while (pending[q.tag] && n < WAIT_CYC) begin
			@(negedge clk);
			n++;
		end
		if (pending[q.tag]) begin
			$display("[%0t] tag %0d was still outstanding when it was needed again",
				$time, q.tag);
			errors++;
			pending[q.tag] = 1'b0;
			outstanding--;
		end
		exp_q[q.tag]   = exp;
		pending[q.tag] = 1'b1;
		outstanding++;
		send_req(q);
	endtask

	task automatic wait_all();
		int n;
		n = 0;
		while (outstanding > 0 && n < WAIT_CYC) begin
			@(negedge clk);
			n++;
		end
		for (int t = 0; t < N_TAG; t++) begin
			if (pending[t]) begin
				$display("[%0t] tag %0d never returned a result", $time, t);
				errors++;
				pending[t] = 1'b0;
			end
		end
		outstanding = 0;
	endtask

	task automatic end_test(input int num, input string name);
		if (errors == test_err0) begin
			n_pass++;
			$display("[%0t] test %0d %s: ok", $time, num, name);
		end else begin
			n_fail++;
			$display("[%0t] test %0d %s: %0d errors", $time, num, name, errors - test_err0);
		end
		test_err0 = errors;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		req_valid   = 1'b0;
		req         = '0;
		tbl_we      = 1'b0;
		tbl_bank    = '0;
		tbl_idx     = '0;
		tbl_entry   = '0;
		seed        = 93;
		errors      = 0;
		test_err0   = 0;
		n_pass      = 0;
		n_fail      = 0;
		outstanding = 0;
		busy_seen   = 1'b0;
		for (int t = 0; t < N_TAG; t++)
			pending[t] = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Nothing moves without requests
		for (int c = 0; c < 10; c++) begin
			@(negedge clk);
			check_level("busy", 1'b0, busy);
			check_level("res_valid", 1'b0, res_valid);
		end
		end_test(1, "idle after reset");

		// Every entry gets defined contents before the first walk
		fill_table(1'b0);

		r = make_req(1, 10'h005, 32'h0001_2345, 32'h0);
		build_chain(r, 1, 1'b0, 20'hABCDE);
		issue(r, expect_res(1, 1'b1, 20'hABCDE, 1));
		wait_all();
		end_test(2, "first probe hit");

		// Two and three links deep, the deeper hit sits right at the probe limit
		r = make_req(2, 10'h013, 32'hDEAD_0040, 32'h0000_0030);
		build_chain(r, 3, 1'b0, 20'h12345);
		issue(r, expect_res(2, 1'b1, 20'h12345, 3));
		wait_all();
		r = make_req(3, 10'h2A0, 32'h0000_7777, 32'h0000_000F);
		build_chain(r, 4, 1'b0, 20'h0BEEF);
		issue(r, expect_res(3, 1'b1, 20'h0BEEF, 4));
		wait_all();
		end_test(3, "chained hits");

		// Invalid start entry that otherwise matches the page
		r = make_req(4, 10'h3FF, 32'hCAFE_F00D, 32'hFFFF_FFFF);
		e = '0;
		e.asid = r.asid;
		e.vpn  = r.vpn;
		e.ppn  = 20'hFFFFF;
		plant(r, e);
		issue(r, expect_res(4, 1'b0, '0, 1));
		wait_all();
		r = make_req(5, 10'h0C3, 32'h0BAD_CAFE, 32'h0000_0100);
		build_chain(r, 3, 1'b1, 20'h55555);
		issue(r, expect_res(5, 1'b0, '0, 3));
		wait_all();
		// The page sits beyond the probe limit
		r = make_req(6, 10'h111, 32'h1357_9BDF, 32'h0000_0402);
		build_chain(r, 6, 1'b0, 20'h77777);
		issue(r, expect_res(6, 1'b0, '0, MAX_PROBES));
		wait_all();
		end_test(4, "misses");

		fill_table(1'b1);
		for (int i = 0; i < N_RAND; i++) begin
			case (i % 4)
				0:       m = '0;
				1:       m = $random(seed);
				2:       m = $random(seed) & 32'hFFFF_0000;
				default: m = 32'h1 << ({$random(seed)} % 32);
			endcase
			rq[i] = make_req(i % N_TAG, $random(seed), $random(seed), m);
			// Half of the pages are placed where their walk starts
			if (i % 2 == 0) begin
				e       = rand_entry();
				e.valid = 1'b1;
				e.asid  = rq[i].asid;
				e.vpn   = rq[i].vpn;
				plant(rq[i], e);
			end
		end
		for (int i = 0; i < N_RAND; i++)
			issue(rq[i], ref_lookup(rq[i]));
		wait_all();
		end_test(5, "random lookups");

		// With a zero asid and mask the hash is vpn[9:0], so all go to bank 0
		busy_seen = 1'b0;
		for (int i = 0; i < N_BURST; i++) begin
			bq[i] = make_req(i, '0, (vaddr_t'($random(seed)) & 32'hFFFF_FC00) |
				vaddr_t'(i << BANK_W), 32'h0);
			if (i % 2 == 0) begin
				e       = rand_entry();
				e.valid = 1'b1;
				e.asid  = bq[i].asid;
				e.vpn   = bq[i].vpn;
				plant(bq[i], e);
			end
		end
		for (int i = 0; i < N_BURST; i++)
			issue(bq[i], ref_lookup(bq[i]));
		wait_all();
		if (!busy_seen) begin
			$display("[%0t] busy never held off the host during the burst", $time);
			errors++;
		end
		end_test(6, "burst to one bank");

		if (uut.u_props.fail_cnt != 0) begin
			$display("%0d assertion failures in the property checker", uut.u_props.fail_cnt);
			errors += uut.u_props.fail_cnt;
		end
		$display("%0d tests passed, %0d tests failed, %0d errors", n_pass, n_fail, errors);
		if (n_fail == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== ipt_mmu.f ====
common/ipt_pkg.sv
hw/ipt_hash.sv
hw/ipt_fifo.sv
hw/ipt_dispatch.sv
hw/ipt_collect.sv
ipt_walk/ipt_table_ram.sv
ipt_walk/ipt_walker.sv
hw/ipt_mmu_top.sv
tb/ipt_mmu_props.sv
tb/ipt_mmu_tb.sv
